// File: verif/decomp_stimulus.txt
# name, zero-chunk mask (hex), bad-response line (-1 none, 0 is the metadata line),
# output stall period in cycles, expected output lines, expected status (done or bus_error)
all_zero_chunks   f  -1  0  16  done
all_copy_chunks   0  -1  0  16  done
mixed_mask_5      5  -1  0  16  done
mixed_mask_a      a  -1  0  16  done
mixed_mask_1      1  -1  1  16  done
mixed_mask_e      e  -1  3  16  done
stall_copy        0  -1  2  16  done
stall_zero        f  -1  4  16  done
stall_mixed       6  -1  5  16  done
err_metadata      0   0  0   0  bus_error
err_first_copy    0   1  0   0  bus_error
err_mid_page      5   6  2  13  bus_error
err_after_zeros   3   1  0   8  bus_error
err_late_copy     8  12  1  11  bus_error
after_reset       9  -1  1  16  done

// File: vlog.f
common/hacd_cfg_pkg.sv
common/hacd_types_pkg.sv
common/line_rd_if.sv
src/line_fifo.sv
decompressor/decompressor.sv
src/hacd_decomp_top.sv
verif/tb_hacd_decomp.sv

// File: Bender.yml
package:
  name: hacd_decomp

sources:
  # packages first, then the interface and RTL in compile order
  - common/hacd_cfg_pkg.sv
  - common/hacd_types_pkg.sv
  - common/line_rd_if.sv
  - src/line_fifo.sv
  - decompressor/decompressor.sv
  - src/hacd_decomp_top.sv

  - target: test
    files:
      - verif/tb_hacd_decomp.sv

// File: verif/tb_hacd_decomp.sv
`timescale 1ns/1ps
`default_nettype none

module tb_hacd_decomp;

	localparam int CLK_PERIOD = 40;

	logic                            clk_i;
	logic                            rst_ni;
	logic                            in_wr_req;
	hacd_types_pkg::line_t           in_data;
	logic [hacd_cfg_pkg::RESP_W-1:0] in_resp;
	logic                            in_full;
	logic                            decomp_start;
	logic                            decomp_done;
	logic                            bus_error;
	logic                            out_rd_req;
	logic                            out_rd_valid;
	hacd_types_pkg::line_t           out_data;
	logic                            out_empty;

	// one entry per test record
	string                             t_name [$];
	logic [hacd_cfg_pkg::N_CHUNKS-1:0] t_mask [$];
	int                                t_err [$];
	int                                t_stall [$];
	int                                t_nout [$];
	hacd_types_pkg::decomp_status_e    t_status [$];

	hacd_types_pkg::line_t exp_q [$]; // model output of the current page
	longint                watchdog_cycles = 0;

	hacd_decomp_top UUT (
		.clk_i       (clk_i),
		.rst_ni      (rst_ni),
		.in_wr_req   (in_wr_req),
		.in_data     (in_data),
		.in_resp     (in_resp),
		.in_full     (in_full),
		.decomp_start(decomp_start),
		.decomp_done (decomp_done),
		.bus_error   (bus_error),
		.out_rd_req  (out_rd_req),
		.out_rd_valid(out_rd_valid),
		.out_data    (out_data),
		.out_empty   (out_empty)
	);

	always #(CLK_PERIOD / 2) clk_i = ~clk_i;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_line(input string name, input hacd_types_pkg::line_t exp,
		input hacd_types_pkg::line_t act);
		if (act !== exp) begin
			fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic check_status(input string name, input hacd_types_pkg::decomp_status_e exp,
		input hacd_types_pkg::decomp_status_e act);
		if (act !== exp) begin
			fail_run($sformatf("Mismatch %s: expected %s, actual %s", name, exp.name(),
				act.name()));
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			fail_run($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
		end
	endtask

	// copied lines in a page, 4 per chunk whose mask bit is clear
	function automatic int copy_lines(input logic [hacd_cfg_pkg::N_CHUNKS-1:0] mask);
		int n;
		n = 0;
		for (int c = 0; c < hacd_cfg_pkg::N_CHUNKS; c++) begin
			if (!mask[c]) begin
				n += hacd_cfg_pkg::LINES_PER_CHUNK;
			end
		end
		return n;
	endfunction

	function automatic hacd_types_pkg::line_t rand_line();
		hacd_types_pkg::line_t l;
		l = '0;
		for (int i = 0; i < hacd_cfg_pkg::LINE_W; i += 32) begin
			l = (l << 32) | hacd_types_pkg::line_t'($urandom);
		end
		return l;
	endfunction

	task automatic read_stimulus();
		int          fd;
		int          n;
		string       text;
		string       name;
		string       stat;
		logic [31:0] mask;
		int          err;
		int          stall;
		int          nout;
		fd = $fopen("verif/decomp_stimulus.txt", "r");
		if (fd == 0) begin
			fail_run("cannot open the stimulus file verif/decomp_stimulus.txt");
		end else begin
			while (!$feof(fd)) begin
				text = "";
				n = $fgets(text, fd);
				if (n > 0 && text.len() > 1 && text.substr(0, 0) != "#") begin
					n = $sscanf(text, "%s %h %d %d %d %s", name, mask, err, stall, nout, stat);
					if (n != 6) begin
						fail_run($sformatf("malformed stimulus record: %s", text));
					end else begin
						t_name.push_back(name);
						t_mask.push_back(mask[hacd_cfg_pkg::N_CHUNKS-1:0]);
						t_err.push_back(err);
						t_stall.push_back(stall);
						t_nout.push_back(nout);
						if (stat == "done") begin
							t_status.push_back(hacd_types_pkg::STATUS_DONE);
						end else if (stat == "bus_error") begin
							t_status.push_back(hacd_types_pkg::STATUS_BUS_ERROR);
						end else begin
							fail_run($sformatf("unknown status %s in test %s", stat, name));
						end
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic apply_reset();
		rst_ni       = 1'b0;
		decomp_start = 1'b0;
		in_wr_req    = 1'b0;
		out_rd_req   = 1'b0;
		repeat (4) @(negedge clk_i);
		rst_ni = 1'b1;
		@(negedge clk_i);
		if (decomp_done || bus_error || out_rd_valid) begin
			fail_run("done, bus_error or output valid not low after reset");
		end
	endtask

	// input FIFO starts each page empty and the decompressor is idle while loading
	task automatic push_line(input hacd_types_pkg::line_t data, input bit bad,
		input int queued, input string name);
		check_flag($sformatf("%s in_full with %0d lines queued", name, queued),
			queued >= int'(hacd_cfg_pkg::FIFO_DEPTH) - 1, in_full);
		in_wr_req = 1'b1;
		in_data   = data;
		in_resp   = bad ? hacd_cfg_pkg::RESP_W'(2) : '0; // slave error code
		@(negedge clk_i);
		in_wr_req = 1'b0;
	endtask

	// push the compressed page and build the expected rebuilt page
	task automatic load_page(input int idx);
		hacd_types_pkg::line_t l;
		int                    in_idx;
		bit                    stop;
		in_idx = 0;
		stop   = (t_err[idx] == 0);
		exp_q.delete();
		l = rand_line();
		l[hacd_cfg_pkg::N_CHUNKS-1:0] = t_mask[idx];
		push_line(l, t_err[idx] == 0, 0, t_name[idx]);
		for (int c = 0; c < hacd_cfg_pkg::N_CHUNKS; c++) begin
			for (int j = 0; j < hacd_cfg_pkg::LINES_PER_CHUNK; j++) begin
				if (t_mask[idx][c]) begin
					if (!stop) exp_q.push_back('0);
				end else begin
					in_idx++;
					l = rand_line();
					push_line(l, in_idx == t_err[idx], in_idx, t_name[idx]);
					if (in_idx == t_err[idx]) stop = 1'b1;
					if (!stop) exp_q.push_back(l);
				end
			end
		end
		if (exp_q.size() != t_nout[idx]) begin
			fail_run($sformatf("test %s: record says %0d output lines, mask gives %0d",
				t_name[idx], t_nout[idx], exp_q.size()));
		end
	endtask

	task automatic run_page(input int idx);
		int                             popped;
		int                             issued;
		int                             stall_cnt;
		hacd_types_pkg::decomp_status_e act_status;
		popped    = 0;
		issued    = 0;
		stall_cnt = 0;
		load_page(idx);
		decomp_start = 1'b1;
		while (!((decomp_done || bus_error) && issued == popped &&
			(popped == exp_q.size() || out_empty))) begin
			@(negedge clk_i);
			out_rd_req = 1'b0;
			if (out_rd_valid) begin
				if (popped >= exp_q.size()) begin
					fail_run($sformatf("test %s: more output lines than expected", t_name[idx]));
				end else begin
					check_line($sformatf("%s line %0d", t_name[idx], popped), exp_q[popped],
						out_data);
					popped++;
				end
			end
			if (stall_cnt > 0) begin
				stall_cnt--;
			end else if (!out_empty && issued < exp_q.size()) begin
				out_rd_req = 1'b1;
				issued++;
				stall_cnt = t_stall[idx];
			end
		end
		act_status = bus_error ? hacd_types_pkg::STATUS_BUS_ERROR : hacd_types_pkg::STATUS_DONE;
		check_status(t_name[idx], t_status[idx], act_status);
		if (popped != exp_q.size()) begin
			fail_run($sformatf("test %s: only %0d of %0d lines came out", t_name[idx], popped,
				exp_q.size()));
		end
		repeat (2) @(negedge clk_i);
		if (!out_empty || out_rd_valid) begin
			fail_run($sformatf("test %s: extra line left in the output FIFO", t_name[idx]));
		end
		if (act_status == hacd_types_pkg::STATUS_DONE) begin
			repeat (3) begin
				@(negedge clk_i);
				if (!decomp_done) fail_run("decomp_done dropped while start was still high");
			end
			decomp_start = 1'b0;
			@(negedge clk_i);
			if (decomp_done) fail_run("decomp_done still high one cycle after start fell");
		end else begin
			decomp_start = 1'b0;
			repeat (3) @(negedge clk_i);
			if (!bus_error) fail_run("bus_error cleared without a reset");
			if (decomp_done) fail_run("decomp_done rose after a bus error");
			apply_reset();
		end
	endtask

	// watchdog limit from the line counts of all tests
	initial begin
		wait (watchdog_cycles > 0);
		#(watchdog_cycles * CLK_PERIOD);
		fail_run($sformatf("timeout: run went past %0d clock cycles", watchdog_cycles));
	end

	initial begin
		longint total;
		int     max_stall;
		clk_i        = 1'b0;
		rst_ni       = 1'b0;
		in_wr_req    = 1'b0;
		in_data      = '0;
		in_resp      = '0;
		decomp_start = 1'b0;
		out_rd_req   = 1'b0;
		void'($urandom(56872));
		read_stimulus();
		total     = 0;
		max_stall = 0;
		foreach (t_name[i]) begin
			total += 1 + copy_lines(t_mask[i]) + t_nout[i];
			if (t_stall[i] > max_stall) max_stall = t_stall[i];
		end
		watchdog_cycles = total * (max_stall + 8) + t_name.size() * 40 + 100;
		apply_reset();
		foreach (t_name[i]) begin
			run_page(i);
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/hacd_decomp_top.sv
`timescale 1ns/1ps
`default_nettype none

module hacd_decomp_top (
	input  logic                              clk_i,
	input  logic                              rst_ni,

	// compressed page in
	input  logic                              in_wr_req,
	input  hacd_types_pkg::line_t             in_data,
	input  logic [hacd_cfg_pkg::RESP_W-1:0]   in_resp,
	output logic                              in_full,

	input  logic                              decomp_start,
	output logic                              decomp_done,
	output logic                              bus_error,

	// rebuilt page out
	input  logic                              out_rd_req,
	output logic                              out_rd_valid,
	output hacd_types_pkg::line_t             out_data,
	output logic                              out_empty
);

	hacd_types_pkg::rd_line_t      in_rec;
	hacd_types_pkg::line_t         dec_wr_data;
	hacd_types_pkg::decomp_state_e dec_state;
	logic                          dec_wr_req;
	logic                          out_full;

	line_rd_if #(.payload_t(hacd_types_pkg::rd_line_t)) in_rd ();
	line_rd_if #(.payload_t(hacd_types_pkg::line_t))    out_rd ();

	assign in_rec.data = in_data;
	assign in_rec.resp = in_resp;

	line_fifo #(
		.payload_t(hacd_types_pkg::rd_line_t)
	) in_fifo (
		.clk_i  (clk_i),
		.rst_ni (rst_ni),
		.wr_req (in_wr_req),
		.wr_data(in_rec),
		.full   (in_full),
		.rd     (in_rd)
	);

	decompressor u_decomp (
		.clk_i       (clk_i),
		.rst_ni      (rst_ni),
		.decomp_start(decomp_start),
		.rd          (in_rd),
		.wrfifo_full (out_full),
		.wr_req      (dec_wr_req),
		.wr_data     (dec_wr_data),
		.decomp_done (decomp_done),
		.state       (dec_state)
	);

	line_fifo #(
		.payload_t(hacd_types_pkg::line_t)
	) out_fifo (
		.clk_i  (clk_i),
		.rst_ni (rst_ni),
		.wr_req (dec_wr_req),
		.wr_data(dec_wr_data),
		.full   (out_full),
		.rd     (out_rd)
	);

	// pop side straight to the pins
	assign out_rd.rd_req = out_rd_req;
	assign out_rd_valid  = out_rd.rd_valid;
	assign out_data      = out_rd.rd_data;
	assign out_empty     = out_rd.empty;

	assign bus_error = (dec_state == hacd_types_pkg::BUS_ERROR); // state is a flop

endmodule

`default_nettype wire

// File: decompressor/decompressor.sv
`timescale 1ns/1ps
`default_nettype none

module decompressor (
	input  logic                          clk_i,
	input  logic                          rst_ni,

	input  logic                          decomp_start,

	// compressed line stream
	line_rd_if.reader                     rd,

	// rebuilt lines
	input  logic                          wrfifo_full,
	output logic                          wr_req,
	output hacd_types_pkg::line_t         wr_data,

	output logic                          decomp_done,
	output hacd_types_pkg::decomp_state_e state
);

	hacd_types_pkg::decomp_state_e n_state;

	logic [hacd_cfg_pkg::N_CHUNKS-1:0] zero_mask;
	logic [hacd_cfg_pkg::N_CHUNKS-1:0] n_zero_mask;
	logic [hacd_cfg_pkg::N_CHUNKS-1:0] chunk_done;
	logic [hacd_cfg_pkg::N_CHUNKS-1:0] n_chunk_done;
	logic [hacd_cfg_pkg::N_CHUNKS-1:0] next_chunk;

	logic [hacd_cfg_pkg::CNT_W-1:0] line_cnt;
	logic [hacd_cfg_pkg::CNT_W-1:0] n_line_cnt;

	hacd_types_pkg::line_t n_wr_data;

	logic n_rd_req;
	logic n_wr_req;
	logic n_decomp_done;
	logic rd_idle;
	logic resp_err;
	logic chunk_full;
	logic page_last;

	// nothing requested and nothing returning
	assign rd_idle  = !rd.rd_req && !rd.rd_valid;
	assign resp_err = rd.rd_valid && (rd.rd_data.resp != '0);

	// lowest chunk not yet rebuilt, one-hot
	assign next_chunk = ~chunk_done & (chunk_done + 1'b1);

	// last line of the chunk is being pushed this cycle
	assign chunk_full = (line_cnt == (hacd_cfg_pkg::CNT_W)'(hacd_cfg_pkg::LINES_PER_CHUNK));
	assign page_last  = &(chunk_done | next_chunk);

	always_comb begin
		n_state       = state;
		n_zero_mask   = zero_mask;
		n_chunk_done  = chunk_done;
		n_line_cnt    = line_cnt;
		n_rd_req      = 1'b0;
		n_wr_req      = 1'b0;
		n_wr_data     = '0;
		n_decomp_done = 1'b0;

		case (state)
			hacd_types_pkg::IDLE: begin
				if (decomp_start && !rd.empty) begin
					n_state      = hacd_types_pkg::METADATA;
					n_chunk_done = '0;
				end
			end

			hacd_types_pkg::METADATA: begin
				n_rd_req = rd_idle && !rd.empty;
				if (resp_err) begin
					n_state = hacd_types_pkg::BUS_ERROR;
				end else if (rd.rd_valid) begin
					n_zero_mask = rd.rd_data.data[hacd_cfg_pkg::N_CHUNKS-1:0];
					n_state     = hacd_types_pkg::EXPAND;
				end
			end

			hacd_types_pkg::EXPAND: begin
				n_line_cnt = '0;
				if (|(next_chunk & zero_mask)) begin
					n_state = hacd_types_pkg::FILL_ZEROS;
				end else begin
					n_state = hacd_types_pkg::COPY_LINES;
				end
			end

			hacd_types_pkg::FILL_ZEROS,
			hacd_types_pkg::COPY_LINES: begin
				if (chunk_full) begin
					n_chunk_done  = chunk_done | next_chunk;
					n_decomp_done = page_last; // done right after the final push
					if (page_last) begin
						n_state = hacd_types_pkg::DONE;
					end else begin
						n_state = hacd_types_pkg::EXPAND;
					end
				end else if (state == hacd_types_pkg::FILL_ZEROS) begin
					if (!wrfifo_full) begin
						n_wr_req   = 1'b1; // zero line, data stays 0
						n_line_cnt = line_cnt + 1'b1;
					end
				end else if (resp_err) begin
					n_state = hacd_types_pkg::BUS_ERROR;
				end else if (rd.rd_valid) begin
					n_wr_req   = 1'b1;
					n_wr_data  = rd.rd_data.data;
					n_line_cnt = line_cnt + 1'b1;
				end else begin
					n_rd_req = rd_idle && !rd.empty && !wrfifo_full;
				end
			end

			hacd_types_pkg::DONE: begin
				if (decomp_start) begin
					n_decomp_done = 1'b1;
				end else begin
					n_state = hacd_types_pkg::IDLE;
				end
			end

			hacd_types_pkg::BUS_ERROR: begin
				n_state = hacd_types_pkg::BUS_ERROR; // only reset leaves
			end

			default: begin
				n_state = hacd_types_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state       <= hacd_types_pkg::IDLE;
			zero_mask   <= '0;
			chunk_done  <= '0;
			line_cnt    <= '0;
			rd.rd_req   <= 1'b0;
			wr_req      <= 1'b0;
			decomp_done <= 1'b0;
		end else begin
			state       <= n_state;
			zero_mask   <= n_zero_mask;
			chunk_done  <= n_chunk_done;
			line_cnt    <= n_line_cnt;
			rd.rd_req   <= n_rd_req;
			wr_req      <= n_wr_req;
			decomp_done <= n_decomp_done;
		end
	end

	always_ff @(posedge clk_i) begin
		wr_data <= n_wr_data;
	end

	// one read in flight, so no request until its data has come back
	assert property (@(posedge clk_i) disable iff (!rst_ni)
		rd.rd_req |=> !rd.rd_req ##1 !rd.rd_req)
		else $error("decompressor: second read while one is outstanding");

	assert property (@(posedge clk_i) disable iff (!rst_ni)
		(state == hacd_types_pkg::IDLE) |-> !wr_req)
		else $error("decompressor: output push while idle");

endmodule

`default_nettype wire

// File: src/line_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module line_fifo #(
	parameter type payload_t = logic
) (
	input  logic     clk_i,
	input  logic     rst_ni,

	// push side
	input  logic     wr_req,
	input  payload_t wr_data,
	output logic     full,

	// pop side
	line_rd_if.fifo  rd
);

	payload_t mem [hacd_cfg_pkg::FIFO_DEPTH];

	logic [hacd_cfg_pkg::PTR_W-1:0] wr_ptr;
	logic [hacd_cfg_pkg::PTR_W-1:0] rd_ptr;
	logic [hacd_cfg_pkg::PTR_W:0]   count;
	logic                           pop;

	assign pop      = rd.rd_req;
	assign rd.empty = (count == '0);

	// early full, one slot still free so an in-flight push fits
	assign full = (count >= (hacd_cfg_pkg::PTR_W + 1)'(hacd_cfg_pkg::FIFO_DEPTH - 1));

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			count       <= '0;
			rd.rd_valid <= 1'b0;
		end else begin
			if (wr_req) begin
				wr_ptr <= wr_ptr + 1'b1; // wraps at depth
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end

			case ({wr_req, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase

			rd.rd_valid <= pop;
		end
	end

	// storage and read register
	always_ff @(posedge clk_i) begin
		if (wr_req) begin
			mem[wr_ptr] <= wr_data;
		end
		if (pop) begin
			rd.rd_data <= mem[rd_ptr];
		end
	end

	// writer must respect the early full flag
	assert property (@(posedge clk_i) disable iff (!rst_ni)
		wr_req |-> (count < (hacd_cfg_pkg::PTR_W + 1)'(hacd_cfg_pkg::FIFO_DEPTH) || pop))
		else $error("line_fifo: push into a full FIFO");

	assert property (@(posedge clk_i) disable iff (!rst_ni)
		rd.rd_req |-> !rd.empty)
		else $error("line_fifo: read request while empty");

endmodule

`default_nettype wire

// File: common/line_rd_if.sv
`timescale 1ns/1ps
`default_nettype none

// pop side of a line FIFO with a registered read port
// rd_valid and rd_data follow an accepted rd_req by one cycle
interface line_rd_if #(
	parameter type payload_t = logic
);

	logic     rd_req;   // only while empty is low
	logic     empty;
	logic     rd_valid;
	payload_t rd_data;

	modport fifo (
		input  rd_req,
		output empty,
		output rd_valid,
		output rd_data
	);

	modport reader (
		output rd_req,
		input  empty,
		input  rd_valid,
		input  rd_data
	);

endinterface

`default_nettype wire

// File: common/hacd_types_pkg.sv
`default_nettype none

package hacd_types_pkg;

	// one memory line as seen on the read and write FIFOs
	typedef logic [hacd_cfg_pkg::LINE_W-1:0] line_t;

	// input FIFO entry, line plus the response code it came back with
	typedef struct packed {
		line_t                           data;
		logic [hacd_cfg_pkg::RESP_W-1:0] resp;
	} rd_line_t;

	// decompressor FSM
	typedef enum logic [2:0] {
		IDLE       = 3'd0,
		METADATA   = 3'd1, // fetch mask line
		EXPAND     = 3'd2, // pick next chunk
		FILL_ZEROS = 3'd3,
		COPY_LINES = 3'd4,
		DONE       = 3'd5, // hold done until start drops
		BUS_ERROR  = 3'd6  // sticky until reset
	} decomp_state_e;

	// outcome of one page
	typedef enum logic {
		STATUS_DONE      = 1'b0,
		STATUS_BUS_ERROR = 1'b1
	} decomp_status_e;

endpackage

`default_nettype wire

// File: common/hacd_cfg_pkg.sv
`default_nettype none

package hacd_cfg_pkg;

	// memory line
	localparam int unsigned LINE_W = 64;
	localparam int unsigned RESP_W = 2; // read response code, zero is okay

	// page layout
	// the metadata line carries one zero-chunk bit per chunk in its low bits
	localparam int unsigned N_CHUNKS        = 4;
	localparam int unsigned LINES_PER_CHUNK = 4;

	// must reach LINES_PER_CHUNK itself, not just LINES_PER_CHUNK-1
	localparam int unsigned CNT_W = $clog2(LINES_PER_CHUNK + 1);

	// line FIFOs
	// deeper than metadata plus a whole page of copied lines
	localparam int unsigned FIFO_DEPTH = 32;
	localparam int unsigned PTR_W      = $clog2(FIFO_DEPTH); // depth is a power of two

endpackage

`default_nettype wire
